// ==== design/ctrlDecoder.sv ====
// Decode-stage control generation
// Main decoder, ALU decoder and branch-sense decode

`timescale 1ns/1ns

module ctrlDecoder (
    input  logic [6:0]              op_i,
    input  logic [2:0]              funct3_i,
    input  logic                    funct7b5_i,
    output pipeCtrlPkg::decodeCtrlT ctrl_o,
    output riscvIsaPkg::immSrcT     immSrc_o
);

    // ALU op classes from the main decoder
    localparam logic [1:0] aluOpAdd   = 2'b00;
    localparam logic [1:0] aluOpSub   = 2'b01;
    localparam logic [1:0] aluOpFunct = 2'b10;

    pipeCtrlPkg::decodeCtrlT mainCtrl;
    pipeCtrlPkg::aluCtrlT    aluCtrlD;
    logic [1:0]              aluOp;
    logic                    rtypeSub;

    // Main decoder
    // Unknown opcodes keep the all-zero word
    always_comb begin
        mainCtrl = '0;
        immSrc_o = riscvIsaPkg::immI;
        aluOp    = aluOpAdd;
        case (op_i)
            riscvIsaPkg::opLoad: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.aluSrc    = 1'b1;
                mainCtrl.resultSrc = pipeCtrlPkg::resMem;
            end
            riscvIsaPkg::opStore: begin
                immSrc_o          = riscvIsaPkg::immS;
                mainCtrl.aluSrc   = 1'b1;
                mainCtrl.memWrite = 1'b1;
            end
            riscvIsaPkg::opRtype: begin
                mainCtrl.regWrite = 1'b1;
                aluOp             = aluOpFunct;
            end
            riscvIsaPkg::opBranch: begin
                immSrc_o        = riscvIsaPkg::immB;
                mainCtrl.branch = 1'b1;
                aluOp           = aluOpSub;
                // Branch sense, other compares are not supported
                case (funct3_i)
                    riscvIsaPkg::f3Beq: mainCtrl.branchNe = 1'b0;
                    riscvIsaPkg::f3Bne: mainCtrl.branchNe = 1'b1;
                    default:            mainCtrl.branchNe = 1'b0;
                endcase
            end
            riscvIsaPkg::opItypeAlu: begin
                mainCtrl.regWrite = 1'b1;
                mainCtrl.aluSrc   = 1'b1;
                aluOp             = aluOpFunct;
            end
            riscvIsaPkg::opJal: begin
                immSrc_o           = riscvIsaPkg::immJ;
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.jump      = 1'b1;
                mainCtrl.resultSrc = pipeCtrlPkg::resPc4;
            end
            riscvIsaPkg::opJalr: begin
                // Target is rs1 plus I immediate
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.aluSrc    = 1'b1;
                mainCtrl.jump      = 1'b1;
                mainCtrl.resultSrc = pipeCtrlPkg::resPc4;
            end
            riscvIsaPkg::opLui: begin
                immSrc_o           = riscvIsaPkg::immU;
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.resultSrc = pipeCtrlPkg::resImm;
            end
            default: begin
                mainCtrl = '0;
            end
        endcase
    end

    // Subtract only for R-type, addi has no funct7
    assign rtypeSub = funct7b5_i & op_i[5];

    // ALU decoder
    always_comb begin
        case (aluOp)
            aluOpSub: aluCtrlD = pipeCtrlPkg::aluSub;
            aluOpFunct: begin
                case (funct3_i)
                    riscvIsaPkg::f3AddSub:
                        aluCtrlD = rtypeSub ? pipeCtrlPkg::aluSub : pipeCtrlPkg::aluAdd;
                    riscvIsaPkg::f3Slt: aluCtrlD = pipeCtrlPkg::aluSlt;
                    riscvIsaPkg::f3Or:  aluCtrlD = pipeCtrlPkg::aluOr;
                    riscvIsaPkg::f3And: aluCtrlD = pipeCtrlPkg::aluAnd;
                    // Undefined funct3 falls back to add
                    default:            aluCtrlD = pipeCtrlPkg::aluAdd;
                endcase
            end
            default: aluCtrlD = pipeCtrlPkg::aluAdd;
        endcase
    end

    // Merge ALU control into the word
    always_comb begin
        ctrl_o         = mainCtrl;
        ctrl_o.aluCtrl = aluCtrlD;
    end

endmodule

// ==== design/hazardIf.sv ====
// Hazard bus between the stage registers and the hazard unit
// Stage status towards hazard detection, stall decision back

`timescale 1ns/1ns

interface hazardIf #(
    parameter int regAddrW = 5
) ();

    // Execute stage holds a load
    logic                loadInEx;
    // Execute destination index, driven at the top level
    logic [regAddrW-1:0] rdE;
    // Write enables of the later stages
    logic                regWriteM;
    logic                regWriteW;
    // Load-use stall request
    logic                lwStall;

    modport regsSide (output loadInEx, output regWriteM, output regWriteW, input lwStall);

    modport hazSide (input loadInEx, input rdE, input regWriteM, input regWriteW,
                     output lwStall);

endinterface

// ==== design/hazardUnit.sv ====
// Hazard detection
// Load-use stall and execute-stage operand forwarding selects

`timescale 1ns/1ns

module hazardUnit #(
    parameter int regAddrW = 5
) (
    input  logic [regAddrW-1:0] rs1D_i,
    input  logic [regAddrW-1:0] rs2D_i,
    input  logic [regAddrW-1:0] rs1E_i,
    input  logic [regAddrW-1:0] rs2E_i,
    input  logic [regAddrW-1:0] rdM_i,
    input  logic [regAddrW-1:0] rdW_i,
    hazardIf.hazSide            haz,
    output pipeCtrlPkg::fwdSelT forwardAE_o,
    output pipeCtrlPkg::fwdSelT forwardBE_o
);

    logic rdEMatch;

    // Forward source for one execute operand
    // Memory stage is newer, so it wins over writeback
    function automatic pipeCtrlPkg::fwdSelT pickFwd(
        input logic [regAddrW-1:0] rs,
        input logic [regAddrW-1:0] rdM,
        input logic [regAddrW-1:0] rdW,
        input logic                wrM,
        input logic                wrW
    );
        pipeCtrlPkg::fwdSelT sel;
        sel = pipeCtrlPkg::fwdNone;
        // x0 is hardwired, never forwarded
        if (rs != '0) begin
            if (wrM && (rs == rdM)) begin
                sel = pipeCtrlPkg::fwdMem;
            end else if (wrW && (rs == rdW)) begin
                sel = pipeCtrlPkg::fwdWb;
            end
        end
        return sel;
    endfunction

    // Decode source matches the load target in execute
    assign rdEMatch = (rs1D_i == haz.rdE) || (rs2D_i == haz.rdE);

    // Load-use stall, x0 destination never stalls
    assign haz.lwStall = haz.loadInEx && rdEMatch && (haz.rdE != '0);

    assign forwardAE_o = pickFwd(rs1E_i, rdM_i, rdW_i, haz.regWriteM, haz.regWriteW);
    assign forwardBE_o = pickFwd(rs2E_i, rdM_i, rdW_i, haz.regWriteM, haz.regWriteW);

endmodule

// ==== design/pipeControl.sv ====
// Pipelined RV32I control path, top level
// Decoder, hazard unit and stage registers joined by the hazard bus

`timescale 1ns/1ns

module pipeControl #(
    parameter int regAddrW = 5
) (
    input  logic                       clk,
    input  logic                       reset,
    // Decode-stage instruction fields
    input  logic [6:0]                 op_i,
    input  logic [2:0]                 funct3_i,
    input  logic                       funct7b5_i,
    // Execute-stage ALU flag
    input  logic                       zeroE_i,
    // Register indexes per stage
    input  logic [regAddrW-1:0]        rs1D_i,
    input  logic [regAddrW-1:0]        rs2D_i,
    input  logic [regAddrW-1:0]        rs1E_i,
    input  logic [regAddrW-1:0]        rs2E_i,
    input  logic [regAddrW-1:0]        rdE_i,
    input  logic [regAddrW-1:0]        rdM_i,
    input  logic [regAddrW-1:0]        rdW_i,
    // Stage controls and strobes
    output logic                       pcSrcE_o,
    output logic                       stallF_o,
    output logic                       stallD_o,
    output logic                       flushD_o,
    output logic                       flushE_o,
    output pipeCtrlPkg::aluCtrlT       aluCtrlE_o,
    output logic                       aluSrcE_o,
    output logic                       memWriteM_o,
    output pipeCtrlPkg::resultSrcT     resultSrcM_o,
    output pipeCtrlPkg::resultSrcT     resultSrcW_o,
    output logic                       regWriteW_o,
    output riscvIsaPkg::immSrcT        immSrcD_o,
    // Operand forwarding selects
    output pipeCtrlPkg::fwdSelT        forwardAE_o,
    output pipeCtrlPkg::fwdSelT        forwardBE_o
);

    pipeCtrlPkg::decodeCtrlT ctrlD;

    hazardIf #(.regAddrW(regAddrW)) hazBus ();

    // Execute destination comes straight from the datapath
    assign hazBus.rdE = rdE_i;

    ctrlDecoder decoder_inst (
        .op_i       (op_i),
        .funct3_i   (funct3_i),
        .funct7b5_i (funct7b5_i),
        .ctrl_o     (ctrlD),
        .immSrc_o   (immSrcD_o)
    );

    hazardUnit #(.regAddrW(regAddrW)) hazard_inst (
        .rs1D_i      (rs1D_i),
        .rs2D_i      (rs2D_i),
        .rs1E_i      (rs1E_i),
        .rs2E_i      (rs2E_i),
        .rdM_i       (rdM_i),
        .rdW_i       (rdW_i),
        .haz         (hazBus.hazSide),
        .forwardAE_o (forwardAE_o),
        .forwardBE_o (forwardBE_o)
    );

    stageRegs regs_inst (
        .clk          (clk),
        .reset        (reset),
        .ctrlD_i      (ctrlD),
        .zeroE_i      (zeroE_i),
        .haz          (hazBus.regsSide),
        .pcSrcE_o     (pcSrcE_o),
        .stallF_o     (stallF_o),
        .stallD_o     (stallD_o),
        .flushD_o     (flushD_o),
        .flushE_o     (flushE_o),
        .aluCtrlE_o   (aluCtrlE_o),
        .aluSrcE_o    (aluSrcE_o),
        .memWriteM_o  (memWriteM_o),
        .resultSrcM_o (resultSrcM_o),
        .resultSrcW_o (resultSrcW_o),
        .regWriteW_o  (regWriteW_o)
    );

endmodule

// ==== design/pipeCtrlPkg.sv ====
// Pipeline control types
// ALU control codes, result source, forward select, decode control word

package pipeCtrlPkg;

    // ALU operation select
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluCtrlT;

    // Writeback result mux select
    typedef enum logic [1:0] {
        resAlu = 2'b00,
        resMem = 2'b01,
        resPc4 = 2'b10,
        resImm = 2'b11
    } resultSrcT;

    // Execute operand source
    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdWb   = 2'b01,
        fwdMem  = 2'b10
    } fwdSelT;

    // Decode-stage control word, carried into the execute register
    // All zero is a bubble: no write, no store, no redirect
    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      jump;
        logic      branch;
        logic      aluSrc;
        // Inverts the zero test for bne
        logic      branchNe;
        resultSrcT resultSrc;
        aluCtrlT   aluCtrl;
    } decodeCtrlT;

endpackage

// ==== design/riscvIsaPkg.sv ====
// RV32I subset encodings used by the control path
// Major opcodes, funct3 values and immediate-format codes

package riscvIsaPkg;

    // Major opcodes, instruction bits [6:0]
    localparam logic [6:0] opLoad     = 7'b0000011;
    localparam logic [6:0] opStore    = 7'b0100011;
    localparam logic [6:0] opRtype    = 7'b0110011;
    localparam logic [6:0] opBranch   = 7'b1100011;
    localparam logic [6:0] opItypeAlu = 7'b0010011;
    localparam logic [6:0] opJal      = 7'b1101111;
    localparam logic [6:0] opJalr     = 7'b1100111;
    localparam logic [6:0] opLui      = 7'b0110111;

    // ALU funct3 values, shared by R-type and I-type
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // Branch funct3 values
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    // Immediate formats for the datapath extender
    // I is also the don't-care value for R-type and unknown opcodes
    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b011,
        immU = 3'b100
    } immSrcT;

endpackage

// ==== design/stageRegs.sv ====
// Execute, memory and writeback control registers
// Branch resolution, stall and flush strobes

`timescale 1ns/1ns

module stageRegs (
    input  logic                       clk,
    input  logic                       reset,
    input  pipeCtrlPkg::decodeCtrlT    ctrlD_i,
    input  logic                       zeroE_i,
    hazardIf.regsSide                  haz,
    output logic                       pcSrcE_o,
    output logic                       stallF_o,
    output logic                       stallD_o,
    output logic                       flushD_o,
    output logic                       flushE_o,
    output pipeCtrlPkg::aluCtrlT       aluCtrlE_o,
    output logic                       aluSrcE_o,
    output logic                       memWriteM_o,
    output pipeCtrlPkg::resultSrcT     resultSrcM_o,
    output pipeCtrlPkg::resultSrcT     resultSrcW_o,
    output logic                       regWriteW_o
);

    pipeCtrlPkg::decodeCtrlT ctrlE;
    logic                    regWriteM;

    // Execute register
    // Flush inserts a bubble on a taken redirect or a load-use stall
    always_ff @(posedge clk) begin
        if (reset || flushE_o) begin
            ctrlE <= '0;
        end else begin
            ctrlE <= ctrlD_i;
        end
    end

    // Memory register
    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM    <= 1'b0;
            memWriteM_o  <= 1'b0;
            resultSrcM_o <= pipeCtrlPkg::resAlu;
        end else begin
            regWriteM    <= ctrlE.regWrite;
            memWriteM_o  <= ctrlE.memWrite;
            resultSrcM_o <= ctrlE.resultSrc;
        end
    end

    // Writeback register
    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteW_o  <= 1'b0;
            resultSrcW_o <= pipeCtrlPkg::resAlu;
        end else begin
            regWriteW_o  <= regWriteM;
            resultSrcW_o <= resultSrcM_o;
        end
    end

    // Execute-stage controls for the datapath
    assign aluCtrlE_o = ctrlE.aluCtrl;
    assign aluSrcE_o  = ctrlE.aluSrc;

    // Branch taken when zero agrees with the sense, jumps always redirect
    assign pcSrcE_o = (ctrlE.branch && (zeroE_i ^ ctrlE.branchNe)) || ctrlE.jump;

    // Stage status towards the hazard unit
    assign haz.loadInEx  = (ctrlE.resultSrc == pipeCtrlPkg::resMem);
    assign haz.regWriteM = regWriteM;
    assign haz.regWriteW = regWriteW_o;

    // Stall holds fetch and decode, flush kills the wrong-path work
    assign stallF_o = haz.lwStall;
    assign stallD_o = haz.lwStall;
    assign flushD_o = pcSrcE_o;
    assign flushE_o = haz.lwStall || pcSrcE_o;

endmodule

// ==== testbench/ctrlModel.svh ====
// Reference model of decode, stage registers and hazard rules
// Compare tasks for each kind of DUT result

`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// Model pipeline state
pipeCtrlPkg::decodeCtrlT   mCtrlE;
logic                      mRegWriteM;
logic                      mMemWriteM;
pipeCtrlPkg::resultSrcT    mResultSrcM;
logic                      mRegWriteW;
pipeCtrlPkg::resultSrcT    mResultSrcW;

// Per-test bookkeeping
string  curTest;
int     testChecks;
int     testErrors;

// Decode rules of the supported RV32I subset
function automatic pipeCtrlPkg::decodeCtrlT decodeModel(
    input logic [6:0] op,
    input logic [2:0] f3,
    input logic       f7b5
);
    pipeCtrlPkg::decodeCtrlT c;
    logic                    byFunct;
    c       = '0;
    byFunct = 1'b0;
    if (op == riscvIsaPkg::opLoad || op == riscvIsaPkg::opRtype ||
        op == riscvIsaPkg::opItypeAlu || op == riscvIsaPkg::opJal ||
        op == riscvIsaPkg::opJalr || op == riscvIsaPkg::opLui) begin
        c.regWrite = 1'b1;
    end
    c.memWrite = (op == riscvIsaPkg::opStore);
    c.jump     = (op == riscvIsaPkg::opJal) || (op == riscvIsaPkg::opJalr);
    c.branch   = (op == riscvIsaPkg::opBranch);
    c.aluSrc   = (op == riscvIsaPkg::opLoad) || (op == riscvIsaPkg::opStore) ||
                 (op == riscvIsaPkg::opItypeAlu) || (op == riscvIsaPkg::opJalr);
    c.branchNe = c.branch && (f3 == riscvIsaPkg::f3Bne);
    if (op == riscvIsaPkg::opLoad) c.resultSrc = pipeCtrlPkg::resMem;
    else if (c.jump) c.resultSrc = pipeCtrlPkg::resPc4;
    else if (op == riscvIsaPkg::opLui) c.resultSrc = pipeCtrlPkg::resImm;
    else c.resultSrc = pipeCtrlPkg::resAlu;
    byFunct = (op == riscvIsaPkg::opRtype) || (op == riscvIsaPkg::opItypeAlu);
    c.aluCtrl = pipeCtrlPkg::aluAdd;
    if (c.branch) begin
        c.aluCtrl = pipeCtrlPkg::aluSub;
    end else if (byFunct) begin
        // Subtract only with funct7 bit 5 on an R-type
        if (f3 == 3'b000 && f7b5 && op == riscvIsaPkg::opRtype) c.aluCtrl = pipeCtrlPkg::aluSub;
        else if (f3 == 3'b010) c.aluCtrl = pipeCtrlPkg::aluSlt;
        else if (f3 == 3'b110) c.aluCtrl = pipeCtrlPkg::aluOr;
        else if (f3 == 3'b111) c.aluCtrl = pipeCtrlPkg::aluAnd;
    end
    return c;
endfunction

// Immediate format per opcode, I for everything else
function automatic riscvIsaPkg::immSrcT immModel(input logic [6:0] op);
    if (op == riscvIsaPkg::opStore) return riscvIsaPkg::immS;
    if (op == riscvIsaPkg::opBranch) return riscvIsaPkg::immB;
    if (op == riscvIsaPkg::opJal) return riscvIsaPkg::immJ;
    if (op == riscvIsaPkg::opLui) return riscvIsaPkg::immU;
    return riscvIsaPkg::immI;
endfunction

// Forward source, newest stage first
function automatic pipeCtrlPkg::fwdSelT fwdModel(input logic [4:0] rs);
    if (rs == 5'd0) return pipeCtrlPkg::fwdNone;
    if (mRegWriteM && rs == rdM) return pipeCtrlPkg::fwdMem;
    if (mRegWriteW && rs == rdW) return pipeCtrlPkg::fwdWb;
    return pipeCtrlPkg::fwdNone;
endfunction

task automatic checkBit(input string what, input logic exp, input logic act);
    testChecks++;
    if (act !== exp) begin
        testErrors++;
        $display("[FAIL] %s %s: expected %b actual %b", curTest, what, exp, act);
    end
endtask

task automatic checkCtrl(input string what, input pipeCtrlPkg::aluCtrlT exp,
                         input pipeCtrlPkg::aluCtrlT act);
    testChecks++;
    if (act !== exp) begin
        testErrors++;
        $display("[FAIL] %s %s: expected %0d actual %0d", curTest, what, exp, act);
    end
endtask

task automatic checkImm(input string what, input riscvIsaPkg::immSrcT exp,
                        input riscvIsaPkg::immSrcT act);
    testChecks++;
    if (act !== exp) begin
        testErrors++;
        $display("[FAIL] %s %s: expected %0d actual %0d", curTest, what, exp, act);
    end
endtask

task automatic checkFwd(input string what, input pipeCtrlPkg::fwdSelT exp,
                        input pipeCtrlPkg::fwdSelT act);
    testChecks++;
    if (act !== exp) begin
        testErrors++;
        $display("[FAIL] %s %s: expected %0d actual %0d", curTest, what, exp, act);
    end
endtask

task automatic checkResult(input string what, input pipeCtrlPkg::resultSrcT exp,
                           input pipeCtrlPkg::resultSrcT act);
    testChecks++;
    if (act !== exp) begin
        testErrors++;
        $display("[FAIL] %s %s: expected %0d actual %0d", curTest, what, exp, act);
    end
endtask

`endif

// ==== testbench/pipeControlTb.sv ====
// Testbench for the pipelined control path
// Clock, reset, LCG stimulus, model stepping, checks and reporting

`timescale 1ns/1ns

module pipeControlTb;

    logic       clk;
    logic       reset;
    logic [6:0] op;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       zeroE;
    logic [4:0] rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;

    logic pcSrcE, stallF, stallD, flushD, flushE, aluSrcE, memWriteM, regWriteW;
    pipeCtrlPkg::aluCtrlT   aluCtrlE;
    pipeCtrlPkg::resultSrcT resultSrcM, resultSrcW;
    riscvIsaPkg::immSrcT    immSrcD;
    pipeCtrlPkg::fwdSelT    forwardAE, forwardBE;

    logic [31:0] rngState = 32'h9b33;
    int          sweepIdx;
    int          totalErrors;
    int          totalChecks;
    int          testsRun;
    int          testsFailed;

    `include "ctrlModel.svh"

    pipeControl #(.regAddrW(5)) pipeControl_inst (
        .clk(clk), .reset(reset), .op_i(op), .funct3_i(funct3), .funct7b5_i(funct7b5),
        .zeroE_i(zeroE), .rs1D_i(rs1D), .rs2D_i(rs2D), .rs1E_i(rs1E), .rs2E_i(rs2E),
        .rdE_i(rdE), .rdM_i(rdM), .rdW_i(rdW), .pcSrcE_o(pcSrcE), .stallF_o(stallF),
        .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE), .aluCtrlE_o(aluCtrlE),
        .aluSrcE_o(aluSrcE), .memWriteM_o(memWriteM), .resultSrcM_o(resultSrcM),
        .resultSrcW_o(resultSrcW), .regWriteW_o(regWriteW), .immSrcD_o(immSrcD),
        .forwardAE_o(forwardAE), .forwardBE_o(forwardBE)
    );

    always #5 clk = ~clk;

    // LCG step with the upper bits returned
    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState >> 16;
    endfunction

    // Index 8 and up gives an arbitrary, mostly illegal, opcode
    function automatic logic [6:0] opFromIdx(input int idx);
        case (idx)
            0: return riscvIsaPkg::opLoad;
            1: return riscvIsaPkg::opStore;
            2: return riscvIsaPkg::opRtype;
            3: return riscvIsaPkg::opBranch;
            4: return riscvIsaPkg::opItypeAlu;
            5: return riscvIsaPkg::opJal;
            6: return riscvIsaPkg::opJalr;
            7: return riscvIsaPkg::opLui;
            default: return 7'(nextRand());
        endcase
    endfunction

    function automatic logic modelLwStall();
        return (mCtrlE.resultSrc == pipeCtrlPkg::resMem) && (rdE != 5'd0) &&
               ((rs1D == rdE) || (rs2D == rdE));
    endfunction

    function automatic logic modelPcSrc();
        return (mCtrlE.branch && (zeroE ^ mCtrlE.branchNe)) || mCtrlE.jump;
    endfunction

    // Model edge on the inputs held before the edge
    task automatic clockModel();
        logic flush;
        flush       = modelLwStall() || modelPcSrc();
        mRegWriteW  = mRegWriteM;
        mResultSrcW = mResultSrcM;
        mRegWriteM  = mCtrlE.regWrite;
        mMemWriteM  = mCtrlE.memWrite;
        mResultSrcM = mCtrlE.resultSrc;
        mCtrlE      = flush ? '0 : decodeModel(op, funct3, funct7b5);
    endtask

    // Mode 0 any, 1 branches and jumps, 2 load heavy, 3 opcode sweep
    task automatic driveInputs(input int mode);
        int pick;
        pick = nextRand() % 9;
        case (mode)
            1: op = (pick < 4) ? riscvIsaPkg::opBranch :
                    (pick < 6) ? riscvIsaPkg::opJal :
                    (pick < 7) ? riscvIsaPkg::opJalr : opFromIdx(nextRand() % 9);
            2: op = (pick < 5) ? riscvIsaPkg::opLoad : opFromIdx(nextRand() % 9);
            3: op = opFromIdx(sweepIdx / 16);
            default: op = opFromIdx(pick);
        endcase
        if (mode == 3) begin
            funct3   = 3'((sweepIdx / 2) % 8);
            funct7b5 = 1'(sweepIdx % 2);
            sweepIdx++;
        end else begin
            funct3   = 3'(nextRand() % 8);
            funct7b5 = 1'(nextRand() % 2);
        end
        zeroE = 1'(nextRand() % 2);
        // Small index range so that matches are frequent
        rs1D = 5'(nextRand() % 4);
        rs2D = 5'(nextRand() % 4);
        rs1E = 5'(nextRand() % 4);
        rs2E = 5'(nextRand() % 4);
        rdE  = 5'(nextRand() % 4);
        rdM  = 5'(nextRand() % 4);
        rdW  = 5'(nextRand() % 4);
    endtask

    task automatic checkAll();
        logic stall;
        stall = modelLwStall();
        checkImm("immSrcD", immModel(op), immSrcD);
        checkCtrl("aluCtrlE", mCtrlE.aluCtrl, aluCtrlE);
        checkBit("aluSrcE", mCtrlE.aluSrc, aluSrcE);
        checkBit("memWriteM", mMemWriteM, memWriteM);
        checkResult("resultSrcM", mResultSrcM, resultSrcM);
        checkResult("resultSrcW", mResultSrcW, resultSrcW);
        checkBit("regWriteW", mRegWriteW, regWriteW);
        checkBit("pcSrcE", modelPcSrc(), pcSrcE);
        checkBit("stallF", stall, stallF);
        checkBit("stallD", stall, stallD);
        checkBit("flushD", modelPcSrc(), flushD);
        checkBit("flushE", stall || modelPcSrc(), flushE);
        checkFwd("forwardAE", fwdModel(rs1E), forwardAE);
        checkFwd("forwardBE", fwdModel(rs2E), forwardBE);
    endtask

    task automatic stepCycle(input int mode);
        @(posedge clk);
        clockModel();
        #1;
        driveInputs(mode);
        #4;
        checkAll();
    endtask

    task automatic finishTest();
        testsRun++;
        totalChecks += testChecks;
        totalErrors += testErrors;
        if (testErrors != 0) testsFailed++;
        $display("%s %s: %0d checks, %0d errors", (testErrors == 0) ? "[PASS]" : "[FAIL]",
                 curTest, testChecks, testErrors);
    endtask

    task automatic runTest(input string name, input int mode, input int cycles);
        curTest    = name;
        testChecks = 0;
        testErrors = 0;
        repeat (cycles) stepCycle(mode);
        finishTest();
    endtask

    initial begin
        int waitCnt;
        clk = 0;
        reset = 1;
        op = '0;
        funct3 = '0;
        funct7b5 = 0;
        zeroE = 1;
        // Matching nonzero indexes expose any stall or forward left on by reset
        {rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW} = {7{5'd1}};
        mCtrlE = '0;
        {mRegWriteM, mMemWriteM, mRegWriteW} = '0;
        mResultSrcM = pipeCtrlPkg::resAlu;
        mResultSrcW = pipeCtrlPkg::resAlu;
        sweepIdx = 0;
        {totalErrors, totalChecks, testsRun, testsFailed} = '0;

        repeat (2) @(posedge clk);
        #1 reset = 0;
        // Bounded wait for reset release
        waitCnt = 0;
        while (reset !== 1'b0 && waitCnt < 20) begin
            @(posedge clk);
            waitCnt++;
        end
        if (reset !== 1'b0) begin
            $display("Timeout: reset never released");
            $display("TESTS FAILED");
            $finish;
        end
        #4;
        curTest = "reset";
        testChecks = 0;
        testErrors = 0;
        checkAll();
        finishTest();

        runTest("decodeSweep", 3, 144);
        runTest("pipelineRandom", 0, 300);
        runTest("branchJump", 1, 300);
        runTest("loadUse", 2, 300);
        runTest("forwarding", 0, 300);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+testbench
design/riscvIsaPkg.sv
design/pipeCtrlPkg.sv
design/hazardIf.sv
design/ctrlDecoder.sv
design/hazardUnit.sv
design/stageRegs.sv
design/pipeControl.sv
testbench/pipeControlTb.sv
